// ==== logic/clic_macros.svh ====
/*
 * Global constants of the interrupt subsystem: source count, widths and
 * the AXI4-Lite register map. Included by the package and all RTL files.
 */
`ifndef CLIC_MACROS_SVH
`define CLIC_MACROS_SVH

// Sources and widths
`define CLIC_NUM_SRC 8           // Interrupt lines
`define CLIC_ID_W    3           // Bits of a source id
`define CLIC_XLEN    32          // Cause word and AXI data

// Register map
`define CLIC_MTH_ADDR 12'h000    // M-mode threshold
`define CLIC_STH_ADDR 12'h004    // S-mode threshold
`define CLIC_SRC_BASE 12'h100    // One word per source from here

`endif

// ==== logic/clic_pkg.sv ====
/*
 * Shared types of the interrupt subsystem. Modules refer to these by
 * scoped name, widths follow the constants in the macro header.
 */
`include "clic_macros.svh"

package clic_pkg;

  // ------------------------------------------------------------------------
  // Privilege encoding
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3               // 2 is reserved
  } priv_t;

  // ------------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------------
  // Interrupt level or threshold
  typedef logic [7:0] level_t;

  // Source number
  typedef logic [`CLIC_ID_W-1:0] src_id_t;

  // Cause word, also AXI read and write data
  typedef logic [`CLIC_XLEN-1:0] xword_t;

  // Register address on the AXI4-Lite port
  typedef logic [11:0] axi_addr_t;

endpackage

// ==== logic/clic_cfg_if.sv ====
/*
 * Interfaces inside the subsystem. clic_cfg_if carries the stored
 * configuration out of the register file, clic_offer_if carries the
 * registered winner and the kill handshake from arbiter to controller.
 */
`include "clic_macros.svh"

interface clic_cfg_if;
  logic [`CLIC_NUM_SRC-1:0] ie;                      // Per-source enable
  clic_pkg::priv_t          prio [`CLIC_NUM_SRC];    // Per-source privilege
  clic_pkg::level_t         lvl  [`CLIC_NUM_SRC];    // Per-source level
  clic_pkg::level_t         mth;                     // M-mode threshold
  clic_pkg::level_t         sth;                     // S-mode threshold

  modport regs (output ie, prio, lvl, mth, sth);
  modport arb  (input ie, prio, lvl);
  modport ctrl (input mth, sth);
endinterface

interface clic_offer_if;
  logic              valid;      // Offer present
  clic_pkg::src_id_t id;
  clic_pkg::level_t  level;
  clic_pkg::priv_t   priv;
  logic              kill_req;   // Arbiter wants to replace the offer
  logic              kill_ack;   // Controller lets it go

  modport arb  (output valid, id, level, priv, kill_req, input kill_ack);
  modport ctrl (input valid, id, level, priv, kill_req, output kill_ack);
endinterface

// ==== logic/clic_reg_file.sv ====
/*
 * AXI4-Lite slave holding the two thresholds and the per-source enable,
 * privilege and level. Writes need AW and W together, reads return data
 * one cycle after the address handshake. Unmapped words read zero.
 */
`include "clic_macros.svh"

module clic_reg_file (
  input  logic                clk_i,
  input  logic                rst_ni,
  // AXI4-Lite slave
  input  clic_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                s_axi_awvalid_i,
  output logic                s_axi_awready_o,
  input  clic_pkg::xword_t    s_axi_wdata_i,
  input  logic                s_axi_wvalid_i,
  output logic                s_axi_wready_o,
  output logic [1:0]          s_axi_bresp_o,
  output logic                s_axi_bvalid_o,
  input  logic                s_axi_bready_i,
  input  clic_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                s_axi_arvalid_i,
  output logic                s_axi_arready_o,
  output clic_pkg::xword_t    s_axi_rdata_o,
  output logic [1:0]          s_axi_rresp_o,
  output logic                s_axi_rvalid_o,
  input  logic                s_axi_rready_i,
  // Stored configuration
  clic_cfg_if.regs            cfg_o
);

  logic                     wr_go, rd_go;      // Handshake this cycle
  logic                     bvalid_q, rvalid_q;
  clic_pkg::xword_t         rdata_d, rdata_q;
  clic_pkg::src_id_t        wr_idx, rd_idx;
  clic_pkg::level_t         mth_q, sth_q;
  logic [`CLIC_NUM_SRC-1:0] ie_q;
  clic_pkg::priv_t          prio_q [`CLIC_NUM_SRC];
  clic_pkg::level_t         lvl_q  [`CLIC_NUM_SRC];

  // Word-aligned hit in the per-source window
  function automatic logic is_src(clic_pkg::axi_addr_t a);
    return (a >= `CLIC_SRC_BASE) && (a < `CLIC_SRC_BASE + 4 * `CLIC_NUM_SRC) &&
           (a[1:0] == 2'b00);
  endfunction

  // ------------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------------
  assign wr_go           = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;  // Blocked by B
  assign rd_go           = s_axi_arvalid_i & ~rvalid_q;                   // Blocked by R
  assign s_axi_awready_o = wr_go;
  assign s_axi_wready_o  = wr_go;
  assign s_axi_arready_o = rd_go;
  assign s_axi_bresp_o   = 2'b00;   // Always OKAY
  assign s_axi_rresp_o   = 2'b00;
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_go)               bvalid_q <= 1'b1;
      else if (s_axi_bready_i) bvalid_q <= 1'b0;   // Held until taken
      if (rd_go)               rvalid_q <= 1'b1;
      else if (s_axi_rready_i) rvalid_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Register storage
  // ------------------------------------------------------------------------
  // Base is aligned to the window size, so low address bits give the index
  assign wr_idx = s_axi_awaddr_i[`CLIC_ID_W+1:2];
  assign rd_idx = s_axi_araddr_i[`CLIC_ID_W+1:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mth_q <= '0;
      sth_q <= '0;
      ie_q  <= '0;                          // All sources off
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        prio_q[i] <= clic_pkg::PRIV_U;
        lvl_q[i]  <= '0;
      end
    end else if (wr_go) begin
      if (s_axi_awaddr_i == `CLIC_MTH_ADDR) begin
        mth_q <= s_axi_wdata_i[7:0];
      end else if (s_axi_awaddr_i == `CLIC_STH_ADDR) begin
        sth_q <= s_axi_wdata_i[7:0];
      end else if (is_src(s_axi_awaddr_i)) begin
        ie_q[wr_idx]   <= s_axi_wdata_i[0];
        prio_q[wr_idx] <= clic_pkg::priv_t'(s_axi_wdata_i[2:1]);
        lvl_q[wr_idx]  <= s_axi_wdata_i[15:8];
      end
      // Anything else is dropped
    end
  end

  // Read mux, layout as in the register map
  always_comb begin
    rdata_d = '0;
    if (s_axi_araddr_i == `CLIC_MTH_ADDR) begin
      rdata_d[7:0] = mth_q;
    end else if (s_axi_araddr_i == `CLIC_STH_ADDR) begin
      rdata_d[7:0] = sth_q;
    end else if (is_src(s_axi_araddr_i)) begin
      rdata_d[0]    = ie_q[rd_idx];
      rdata_d[2:1]  = prio_q[rd_idx];
      rdata_d[15:8] = lvl_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_go) rdata_q <= rdata_d;          // Captured with the AR handshake
  end

  // Configuration out
  assign cfg_o.ie   = ie_q;
  assign cfg_o.prio = prio_q;
  assign cfg_o.lvl  = lvl_q;
  assign cfg_o.mth  = mth_q;
  assign cfg_o.sth  = sth_q;

endmodule

// ==== logic/clic_arbiter.sv ====
/*
 * Picks the pending source with the highest level, lowest id on a tie,
 * and registers it as the offer. A changed winner is only loaded after
 * the controller acknowledges the kill request.
 */
`include "clic_macros.svh"

module clic_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`CLIC_NUM_SRC-1:0] irq_src_i,   // Level-sensitive lines
  clic_cfg_if.arb                  cfg_i,
  clic_offer_if.arb                offer_o
);

  logic              best_vld;
  clic_pkg::src_id_t best_id;
  clic_pkg::level_t  best_lvl;
  clic_pkg::priv_t   best_priv;
  logic              valid_q, kill_q;
  clic_pkg::src_id_t id_q;
  clic_pkg::level_t  lvl_q;
  clic_pkg::priv_t   priv_q;
  logic              differ, kill_hs, load;

  // ------------------------------------------------------------------------
  // Winner search
  // ------------------------------------------------------------------------
  always_comb begin
    best_vld = 1'b0;
    best_id  = '0;
    best_lvl = '0;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      // Strict compare keeps the lower id on equal levels
      if (irq_src_i[i] && cfg_i.ie[i] && (!best_vld || cfg_i.lvl[i] > best_lvl)) begin
        best_vld = 1'b1;
        best_id  = clic_pkg::src_id_t'(i);
        best_lvl = cfg_i.lvl[i];
      end
    end
  end

  assign best_priv = cfg_i.prio[best_id];

  // ------------------------------------------------------------------------
  // Offer register and kill control
  // ------------------------------------------------------------------------
  // Offer stale, also when no candidate is left
  assign differ  = valid_q & (~best_vld | (best_id != id_q) |
                              (best_lvl != lvl_q) | (best_priv != priv_q));
  assign kill_hs = kill_q & offer_o.kill_ack;
  assign load    = ~valid_q | kill_hs;     // Free to take the current winner

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      kill_q  <= 1'b0;
    end else begin
      if (load)        valid_q <= best_vld;
      if (kill_hs)     kill_q  <= 1'b0;
      else if (differ) kill_q  <= 1'b1;     // Held until acknowledged
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q   <= best_id;
      lvl_q  <= best_lvl;
      priv_q <= best_priv;
    end
  end

  assign offer_o.valid    = valid_q;
  assign offer_o.id       = id_q;
  assign offer_o.level    = lvl_q;
  assign offer_o.priv     = priv_q;
  assign offer_o.kill_req = kill_q;

endmodule

// ==== logic/clic_irq_ctrl.sv ====
/*
 * Decides whether the core takes the offered interrupt, packs the cause
 * word and tracks the interrupt in flight. Kill requests are answered
 * only while nothing is in flight and nothing is requested.
 */
`include "clic_macros.svh"

module clic_irq_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Core state
  input  clic_pkg::priv_t   priv_lvl_i,
  input  logic              sie_i,
  input  clic_pkg::level_t  mil_i,
  input  clic_pkg::level_t  sil_i,
  // From register file and arbiter
  clic_cfg_if.ctrl          cfg_i,
  clic_offer_if.ctrl        offer_i,
  // To core
  input  logic              irq_ready_i,    // Core takes the request
  output logic              irq_req_o,
  output clic_pkg::xword_t  irq_cause_o
);

  clic_pkg::level_t max_mth, max_sth;   // Effective thresholds
  logic             take;
  logic             inflight_d, inflight_q;

  // ------------------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------------------
  assign max_mth = (cfg_i.mth > mil_i) ? cfg_i.mth : mil_i;
  assign max_sth = (cfg_i.sth > sil_i) ? cfg_i.sth : sil_i;

  always_comb begin
    take = 1'b0;
    case (priv_lvl_i)
      clic_pkg::PRIV_M: take = (offer_i.priv == clic_pkg::PRIV_M) &&
                               (offer_i.level > max_mth);        // Above threshold only
      clic_pkg::PRIV_S: take = (offer_i.priv == clic_pkg::PRIV_M) ||
                               ((offer_i.priv == clic_pkg::PRIV_S) &&
                                (offer_i.level > max_sth) && sie_i);
      clic_pkg::PRIV_U: take = (offer_i.priv == clic_pkg::PRIV_M) ||
                               ((offer_i.priv == clic_pkg::PRIV_S) && sie_i);
      default:          take = 1'b0;
    endcase
  end

  // Request stays up while in flight, no fresh request under a pending kill
  assign irq_req_o = offer_i.valid & take & (inflight_q | ~offer_i.kill_req);

  // ------------------------------------------------------------------------
  // Cause word
  // ------------------------------------------------------------------------
  assign irq_cause_o = {1'b1,                                // Interrupt flag
                        {(`CLIC_XLEN - 25){1'b0}},
                        offer_i.level,                       // Bits 23:16
                        {(16 - `CLIC_ID_W){1'b0}},
                        offer_i.id};                         // Zero-extended id

  // ------------------------------------------------------------------------
  // Kill control
  // ------------------------------------------------------------------------
  assign offer_i.kill_ack = offer_i.kill_req & ~inflight_q & ~irq_req_o;
  // Set on request, cleared by take or kill
  assign inflight_d = inflight_q ? ~(irq_ready_i | offer_i.kill_ack) : irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) inflight_q <= 1'b0;
    else         inflight_q <= inflight_d;
  end

endmodule

// ==== logic/clic_top.sv ====
/*
 * Top level of the interrupt subsystem. AXI4-Lite register port, source
 * lines and core-side signals as plain ports, wired through the
 * configuration and offer interfaces to the three blocks.
 */
`include "clic_macros.svh"

module clic_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // AXI4-Lite register port
  input  clic_pkg::axi_addr_t      s_axi_awaddr_i,
  input  logic                     s_axi_awvalid_i,
  output logic                     s_axi_awready_o,
  input  clic_pkg::xword_t         s_axi_wdata_i,
  input  logic                     s_axi_wvalid_i,
  output logic                     s_axi_wready_o,
  output logic [1:0]               s_axi_bresp_o,
  output logic                     s_axi_bvalid_o,
  input  logic                     s_axi_bready_i,
  input  clic_pkg::axi_addr_t      s_axi_araddr_i,
  input  logic                     s_axi_arvalid_i,
  output logic                     s_axi_arready_o,
  output clic_pkg::xword_t         s_axi_rdata_o,
  output logic [1:0]               s_axi_rresp_o,
  output logic                     s_axi_rvalid_o,
  input  logic                     s_axi_rready_i,
  // Interrupt sources
  input  logic [`CLIC_NUM_SRC-1:0] irq_src_i,
  // Core side
  input  clic_pkg::priv_t          priv_lvl_i,
  input  logic                     sie_i,
  input  clic_pkg::level_t         mil_i,
  input  clic_pkg::level_t         sil_i,
  input  logic                     irq_ready_i,
  output logic                     irq_req_o,
  output clic_pkg::xword_t         irq_cause_o
);

  clic_cfg_if   cfg ();
  clic_offer_if offer ();

  clic_reg_file u_reg_file (
    .clk_i, .rst_ni,
    .s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
    .s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
    .cfg_o (cfg)
  );

  clic_arbiter u_arbiter (
    .clk_i, .rst_ni,
    .irq_src_i,
    .cfg_i   (cfg),
    .offer_o (offer)
  );

  clic_irq_ctrl u_irq_ctrl (
    .clk_i, .rst_ni,
    .priv_lvl_i, .sie_i, .mil_i, .sil_i,
    .cfg_i   (cfg),
    .offer_i (offer),
    .irq_ready_i, .irq_req_o, .irq_cause_o
  );

endmodule

// ==== testbench/clic_asserts.sv ====
/*
 * Concurrent checks on the core-side controller, bound into every
 * clic_irq_ctrl instance. Held cause, kill blocking, offer stability.
 */
`include "clic_macros.svh"

module clic_asserts (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_i,
  input logic              ready_i,
  input clic_pkg::xword_t  cause_i,
  input logic              inflight_i,
  input logic              valid_i,
  input clic_pkg::src_id_t id_i,
  input clic_pkg::level_t  level_i,
  input clic_pkg::priv_t   priv_i,
  input logic              kill_req_i,
  input logic              kill_ack_i
);

  // Cause keeps its flag and value while the request waits in flight
  a_cause_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && inflight_i) |-> (cause_i[`CLIC_XLEN-1] && $stable(cause_i)))
    else $error("cause word changed or lost its flag during a pending request");

  // Untaken request sets the flag and blocks the kill
  a_kill_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !ready_i) |=> (inflight_i && !kill_ack_i))
    else $error("kill acknowledged while an interrupt is in flight");

  // Offer only moves in a kill handshake
  a_offer_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !(kill_req_i && kill_ack_i)) |=>
      (valid_i && $stable(id_i) && $stable(level_i) && $stable(priv_i)))
    else $error("offer changed without a kill handshake");

endmodule

bind clic_irq_ctrl clic_asserts u_asserts (
  .clk_i, .rst_ni,
  .req_i      (irq_req_o),
  .ready_i    (irq_ready_i),
  .cause_i    (irq_cause_o),
  .inflight_i (inflight_q),
  .valid_i    (offer_i.valid),
  .id_i       (offer_i.id),
  .level_i    (offer_i.level),
  .priv_i     (offer_i.priv),
  .kill_req_i (offer_i.kill_req),
  .kill_ack_i (offer_i.kill_ack)
);

// ==== testbench/tb_clic.sv ====
/*
 * Testbench for the interrupt subsystem. Writes the register map over
 * AXI4-Lite, drives source lines and core state, and predicts request and
 * cause from a model of the registers. One line per test, then a summary.
 */
`include "clic_macros.svh"

module tb_clic;

  localparam int unsigned SEED = 65432;
  localparam int N_MTH  = 200;                  // Threshold trials
  localparam int N_PRIV = 40;                   // Privilege trials
  localparam int N_ARB  = 16;                   // Arbitration rounds
  // Cycles per trial (drain, writes, settle, probe) plus fixed tests and 40% margin
  localparam int CYC_LIMIT = (N_MTH * 14 + N_PRIV * 17 + N_ARB * 32 + 300) * 7 / 5;

  logic                     clk_i, rst_ni;
  clic_pkg::axi_addr_t      s_axi_awaddr_i, s_axi_araddr_i;
  logic                     s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i;
  logic                     s_axi_arvalid_i, s_axi_rready_i;
  clic_pkg::xword_t         s_axi_wdata_i, s_axi_rdata_o, irq_cause_o;
  logic                     s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o;
  logic                     s_axi_arready_o, s_axi_rvalid_o;
  logic [1:0]               s_axi_bresp_o, s_axi_rresp_o;
  logic [`CLIC_NUM_SRC-1:0] irq_src_i;
  clic_pkg::priv_t          priv_lvl_i;
  logic                     sie_i, irq_ready_i, irq_req_o;
  clic_pkg::level_t         mil_i, sil_i;

  // Register model kept in step with every write
  logic [`CLIC_NUM_SRC-1:0] m_ie;
  clic_pkg::priv_t          m_priv [`CLIC_NUM_SRC];
  clic_pkg::level_t         m_lvl  [`CLIC_NUM_SRC];
  clic_pkg::level_t         m_mth, m_sth;

  string tname;                                 // Current test
  logic  armed;                                 // Compare process enabled
  int    errors, total_chk, t_err, t_chk, cycles;

  clic_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYC_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: no result after %0d clock cycles", cycles);
    $display("** FAIL **");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic logic exp_req(logic vld, clic_pkg::priv_t cur, clic_pkg::priv_t sp,
                                   clic_pkg::level_t lv);
    clic_pkg::level_t em, es;
    em = (m_mth > mil_i) ? m_mth : mil_i;       // Effective M threshold
    es = (m_sth > sil_i) ? m_sth : sil_i;
    if (!vld) return 1'b0;
    case (cur)
      clic_pkg::PRIV_M: return (sp == clic_pkg::PRIV_M) && (lv > em);
      clic_pkg::PRIV_S: return (sp == clic_pkg::PRIV_M) ||
                               ((sp == clic_pkg::PRIV_S) && (lv > es) && sie_i);
      clic_pkg::PRIV_U: return (sp == clic_pkg::PRIV_M) || ((sp == clic_pkg::PRIV_S) && sie_i);
      default:          return 1'b0;
    endcase
  endfunction

  function automatic clic_pkg::xword_t exp_cause(int id, clic_pkg::level_t lv);
    return {1'b1, 7'b0, lv, 16'(id)};
  endfunction

  // Expected winner or -1 when nothing is pending
  function automatic int winner();
    int top, w;
    top = -1;
    w   = -1;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (irq_src_i[i] && m_ie[i] && int'(m_lvl[i]) > top) top = int'(m_lvl[i]);
    end
    for (int i = `CLIC_NUM_SRC - 1; i >= 0; i--) begin
      if (irq_src_i[i] && m_ie[i] && int'(m_lvl[i]) == top) w = i;   // Lowest id kept
    end
    return w;
  endfunction

  function automatic clic_pkg::priv_t rand_priv();
    case ($urandom_range(0, 2))
      0:       return clic_pkg::PRIV_U;
      1:       return clic_pkg::PRIV_S;
      default: return clic_pkg::PRIV_M;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Checks and reporting
  // ------------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    t_chk++;
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      t_err++;
    end
  endtask

  task automatic complain(input string what);
    $display("ERROR in test %s: %s", tname, what);
    t_err++;
  endtask

  task automatic end_test();
    $display("test %-6s %4d checks, %0d errors", tname, t_chk, t_err);
    errors    += t_err;
    total_chk += t_chk;
    t_err = 0;
    t_chk = 0;
  endtask

  always @(posedge clk_i) begin : compare
    int w;
    if (armed) begin
      w = winner();
      if (w < 0) begin
        check(tname, 32'd0, irq_req_o);         // No offer means no request
      end else begin
        check(tname, exp_req(1'b1, priv_lvl_i, m_priv[w], m_lvl[w]), irq_req_o);
        check(tname, exp_cause(w, m_lvl[w]), irq_cause_o);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Bus and stimulus tasks entered and left at a falling edge
  // ------------------------------------------------------------------------
  task automatic axi_write(input clic_pkg::axi_addr_t addr, input clic_pkg::xword_t data);
    s_axi_awaddr_i  = addr;
    s_axi_wdata_i   = data;
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i  = 1'b1;
    do @(posedge clk_i); while (!(s_axi_awready_o && s_axi_wready_o));
    @(negedge clk_i);
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    while (!s_axi_bvalid_o) @(negedge clk_i);
    check(tname, 32'd0, s_axi_bresp_o);         // OKAY
    @(negedge clk_i);                           // B taken since bready is high
  endtask

  task automatic axi_read(input clic_pkg::axi_addr_t addr, output clic_pkg::xword_t data);
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    do @(posedge clk_i); while (!s_axi_arready_o);
    @(negedge clk_i);
    s_axi_arvalid_i = 1'b0;
    while (!s_axi_rvalid_o) @(negedge clk_i);
    data = s_axi_rdata_o;
    check(tname, 32'd0, s_axi_rresp_o);         // OKAY
    @(negedge clk_i);
  endtask

  task automatic set_src(input int id, input logic en, input clic_pkg::priv_t p,
                         input clic_pkg::level_t lv);
    m_ie[id]   = en;
    m_priv[id] = p;
    m_lvl[id]  = lv;
    axi_write(`CLIC_SRC_BASE + 12'(4 * id), {16'h0, lv, 5'h0, p, en});
  endtask

  task automatic set_th(input logic is_s, input clic_pkg::level_t v);
    if (is_s) begin
      m_sth = v;
      axi_write(`CLIC_STH_ADDR, {24'h0, v});
    end else begin
      m_mth = v;
      axi_write(`CLIC_MTH_ADDR, {24'h0, v});
    end
  endtask

  // Drop all lines while the core takes anything requested until the offer is gone
  task automatic drain();
    int n;
    irq_src_i = '0;
    n = 0;
    while (dut.offer.valid && n < 8) begin
      irq_ready_i = irq_req_o;
      @(negedge clk_i);
      n++;
    end
    irq_ready_i = 1'b0;
    if (dut.offer.valid) complain("offer still valid after all sources dropped");
  endtask

  function automatic logic unsettled();
    return (dut.offer.valid !== (winner() >= 0)) || dut.offer.kill_req;
  endfunction

  task automatic settle();
    int n;
    n = 0;
    while (unsettled() && n < 4) begin
      @(negedge clk_i);
      n++;
    end
    if (unsettled()) complain("offer did not settle within 4 cycles");
  endtask

  // Compare on the next two rising edges
  task automatic probe();
    armed = 1'b1;
    repeat (2) @(negedge clk_i);
    armed = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin : main
    clic_pkg::xword_t    rd, mth_w, sth_w;
    clic_pkg::xword_t    wv [`CLIC_NUM_SRC];
    clic_pkg::axi_addr_t holes [3];
    int                  id;
    void'($urandom(SEED));
    rst_ni          = 1'b0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b1;                     // Responses always taken
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b1;
    irq_src_i       = '1;                       // Lines high through reset
    priv_lvl_i      = clic_pkg::PRIV_M;
    sie_i           = 1'b0;
    mil_i           = '0;
    sil_i           = '0;
    irq_ready_i     = 1'b0;
    m_ie            = '0;
    m_mth           = '0;
    m_sth           = '0;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      m_priv[i] = clic_pkg::PRIV_U;
      m_lvl[i]  = '0;
    end
    armed     = 1'b0;
    errors    = 0;
    total_chk = 0;
    t_err     = 0;
    t_chk     = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state
    tname = "reset";
    for (int k = 0; k < 2; k++) begin
      check(tname, 32'd0, irq_req_o);
      check(tname, 32'd0, s_axi_bvalid_o);
      check(tname, 32'd0, s_axi_rvalid_o);
      @(negedge clk_i);
    end
    irq_src_i = '0;
    end_test();

    // Register write and read back
    tname = "regs";
    holes = '{12'h008, `CLIC_SRC_BASE + 12'h002, `CLIC_SRC_BASE + 12'(4 * `CLIC_NUM_SRC)};
    mth_w = $urandom();
    sth_w = $urandom();
    axi_write(`CLIC_MTH_ADDR, mth_w);
    axi_write(`CLIC_STH_ADDR, sth_w);
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      wv[i] = $urandom();
      axi_write(`CLIC_SRC_BASE + 12'(4 * i), wv[i]);
    end
    foreach (holes[h]) axi_write(holes[h], 32'hffff_ffff);   // Must be dropped
    axi_read(`CLIC_MTH_ADDR, rd);
    check(tname, mth_w & 32'h0000_00ff, rd);
    axi_read(`CLIC_STH_ADDR, rd);
    check(tname, sth_w & 32'h0000_00ff, rd);
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      axi_read(`CLIC_SRC_BASE + 12'(4 * i), rd);
      check(tname, wv[i] & 32'h0000_ff07, rd);  // Level, privilege, enable
    end
    foreach (holes[h]) begin
      axi_read(holes[h], rd);
      check(tname, 32'd0, rd);
    end
    set_th(1'b0, 8'd0);
    set_th(1'b1, 8'd0);
    for (int i = 0; i < `CLIC_NUM_SRC; i++) set_src(i, 1'b0, clic_pkg::PRIV_U, 8'd0);
    end_test();

    // M-mode threshold against level and mil
    tname = "mth";
    id    = $urandom_range(0, `CLIC_NUM_SRC - 1);
    for (int n = 0; n < N_MTH; n++) begin
      drain();
      mil_i = clic_pkg::level_t'($urandom());
      set_th(1'b0, clic_pkg::level_t'($urandom()));
      set_src(id, 1'b1, clic_pkg::PRIV_M, clic_pkg::level_t'($urandom()));
      irq_src_i[id] = 1'b1;
      settle();
      probe();
    end
    end_test();

    // Privilege, sie and S threshold
    tname = "priv";
    for (int n = 0; n < N_PRIV; n++) begin
      drain();
      priv_lvl_i = rand_priv();
      sie_i      = 1'($urandom_range(0, 1));
      sil_i      = clic_pkg::level_t'($urandom());
      mil_i      = clic_pkg::level_t'($urandom());
      set_th(1'b1, clic_pkg::level_t'($urandom()));
      set_src(id, 1'b1, rand_priv(), clic_pkg::level_t'($urandom()));
      irq_src_i[id] = 1'b1;
      settle();
      probe();
    end
    end_test();

    // Several sources at once with levels from a small set so ties occur
    tname      = "arb";
    priv_lvl_i = clic_pkg::PRIV_M;
    mil_i      = '0;
    set_th(1'b0, 8'd0);
    for (int n = 0; n < N_ARB; n++) begin
      drain();
      for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
        set_src(i, $urandom_range(0, 3) != 0, clic_pkg::PRIV_M,
                clic_pkg::level_t'(10 + 60 * $urandom_range(0, 3)));
      end
      for (int i = 0; i < `CLIC_NUM_SRC; i++) irq_src_i[i] = 1'($urandom_range(0, 1));
      settle();
      probe();
    end
    end_test();

    // Higher source arrives while the first one is in flight
    tname = "kill";
    drain();
    set_src(1, 1'b1, clic_pkg::PRIV_M, 8'd50);
    set_src(5, 1'b1, clic_pkg::PRIV_M, 8'd200);
    irq_src_i[1] = 1'b1;
    settle();
    check(tname, 32'd1, irq_req_o);
    check(tname, exp_cause(1, 8'd50), irq_cause_o);
    irq_src_i[5] = 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check(tname, 32'd1, irq_req_o);           // Frozen until taken
      check(tname, exp_cause(1, 8'd50), irq_cause_o);
    end
    irq_ready_i = 1'b1;
    @(negedge clk_i);
    irq_ready_i = 1'b0;
    settle();
    check(tname, 32'd1, irq_req_o);
    check(tname, exp_cause(5, 8'd200), irq_cause_o);
    end_test();

    $display("Summary: %0d checks, %0d errors", total_chk, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== clic.f ====
+incdir+logic
logic/clic_pkg.sv
logic/clic_cfg_if.sv
logic/clic_reg_file.sv
logic/clic_arbiter.sv
logic/clic_irq_ctrl.sv
logic/clic_top.sv
testbench/clic_asserts.sv
testbench/tb_clic.sv

// ==== Bender.yml ====
package:
  name: clic

export_include_dirs:
  - logic

sources:
  # RTL in compile order
  - logic/clic_pkg.sv
  - logic/clic_cfg_if.sv
  - logic/clic_reg_file.sv
  - logic/clic_arbiter.sv
  - logic/clic_irq_ctrl.sv
  - logic/clic_top.sv
  # Testbench, top module tb_clic
  - target: test
    files:
      - testbench/clic_asserts.sv
      - testbench/tb_clic.sv
